// File: source/riscv_pkg.sv
package riscv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // major opcodes used by this core
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 encodings shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // selects sub and the arithmetic shifts
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t insn;
  } decode_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    insn;
    alu_op_e  alu_op;
    reg_idx_t rd;
    logic     rd_we;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    imm;
    logic     a_is_pc;
    logic     b_is_imm;
    logic     is_ecall;
  } exec_t;

  // also the retire trace seen at the top level
  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    insn;
    logic     rd_we;
    reg_idx_t rd;
    word_t    rd_data;
    logic     is_ecall;
  } wb_t;

endpackage

// File: source/instr_mem.sv
module instr_mem #(
  parameter int IMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          load_en,
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
  input  riscv_pkg::word_t              load_insn,
  input  riscv_pkg::word_t              fetch_pc,
  output riscv_pkg::word_t              fetch_insn
);
  import riscv_pkg::*;

  localparam int AW = $clog2(IMEM_WORDS);

  word_t mem [IMEM_WORDS];

  // load port used while the core is idle
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_insn;
    end
  end

  // byte address to word index
  assign fetch_insn = mem[fetch_pc[AW+1:2]];

endmodule

// File: source/fetch_unit.sv
module fetch_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  input  logic               stop_fetch,
  input  riscv_pkg::word_t   fetch_insn,
  output riscv_pkg::word_t   fetch_pc,
  output riscv_pkg::decode_t dec
);
  import riscv_pkg::*;

  logic stopped;
  logic advance;

  // ecall in decode blocks this edge already
  assign advance = run && !stopped && !stop_fetch;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_pc <= '0;
      stopped  <= 1'b0;
    end else begin
      stopped <= stopped | stop_fetch;
      if (advance) begin
        fetch_pc <= fetch_pc + word_t'(4);
      end
    end
  end

  // decode register gets a bubble when not advancing
  always_ff @(posedge clk) begin
    dec.pc   <= fetch_pc;
    dec.insn <= fetch_insn;
    if (rst) begin
      dec.valid <= 1'b0;
    end else begin
      dec.valid <= advance;
    end
  end

endmodule

// File: source/decode_unit.sv
module decode_unit (
  input  logic                clk,
  input  logic                rst,
  input  riscv_pkg::decode_t  dec,
  input  riscv_pkg::word_t    rs1_data,
  input  riscv_pkg::word_t    rs2_data,
  output riscv_pkg::reg_idx_t rs1,
  output riscv_pkg::reg_idx_t rs2,
  output logic                stop_fetch,
  output riscv_pkg::exec_t    exe
);
  import riscv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  word_t      imm_i;
  word_t      imm_sh;
  word_t      imm_u;
  alu_op_e    alu_op;
  word_t      imm;
  logic       a_is_pc;
  logic       b_is_imm;
  logic       writes;
  logic       is_ecall;
  logic       alt;

  assign opcode = dec.insn[6:0];
  assign rd     = dec.insn[11:7];
  assign funct3 = dec.insn[14:12];
  assign rs1    = dec.insn[19:15];
  assign rs2    = dec.insn[24:20];
  assign funct7 = dec.insn[31:25];
  assign alt    = (funct7 == FUNCT7_ALT);

  assign imm_i  = {{20{dec.insn[31]}}, dec.insn[31:20]};
  assign imm_sh = {27'd0, dec.insn[24:20]};
  assign imm_u  = {dec.insn[31:12], 12'd0};

  always_comb begin
    alu_op   = ALU_ADD;
    imm      = imm_i;
    a_is_pc  = 1'b0;
    b_is_imm = 1'b0;
    writes   = 1'b0;
    is_ecall = 1'b0;
    case (opcode)
      OPC_OP_IMM: begin
        b_is_imm = 1'b1;
        writes   = 1'b1;
        case (funct3)
          F3_ADD:  alu_op = ALU_ADD;
          F3_SLT:  alu_op = ALU_SLT;
          F3_SLTU: alu_op = ALU_SLTU;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          F3_SLL: begin
            alu_op = ALU_SLL;
            imm    = imm_sh;
            writes = (funct7 == 7'd0);
          end
          F3_SR: begin
            alu_op = alt ? ALU_SRA : ALU_SRL;
            imm    = imm_sh;
            writes = (funct7 == 7'd0) || alt;
          end
          default: writes = 1'b0;
        endcase
      end
      OPC_OP: begin
        // alt funct7 is only legal on add/sub and the right shifts
        writes = (funct7 == 7'd0) || (alt && (funct3 == F3_ADD || funct3 == F3_SR));
        case (funct3)
          F3_ADD:  alu_op = alt ? ALU_SUB : ALU_ADD;
          F3_SLL:  alu_op = ALU_SLL;
          F3_SLT:  alu_op = ALU_SLT;
          F3_SLTU: alu_op = ALU_SLTU;
          F3_XOR:  alu_op = ALU_XOR;
          F3_SR:   alu_op = alt ? ALU_SRA : ALU_SRL;
          F3_OR:   alu_op = ALU_OR;
          default: alu_op = ALU_AND;
        endcase
      end
      OPC_LUI: begin
        alu_op   = ALU_PASS_B;
        imm      = imm_u;
        b_is_imm = 1'b1;
        writes   = 1'b1;
      end
      OPC_AUIPC: begin
        imm      = imm_u;
        a_is_pc  = 1'b1;
        b_is_imm = 1'b1;
        writes   = 1'b1;
      end
      OPC_SYSTEM: is_ecall = (dec.insn[31:7] == 25'd0);
      default: writes = 1'b0;
    endcase
  end

  assign stop_fetch = dec.valid && is_ecall;

  // execute register takes reg values from the write-through file
  always_ff @(posedge clk) begin
    exe.pc       <= dec.pc;
    exe.insn     <= dec.insn;
    exe.alu_op   <= alu_op;
    exe.rd       <= rd;
    exe.rs1      <= rs1;
    exe.rs2      <= rs2;
    exe.rs1_data <= rs1_data;
    exe.rs2_data <= rs2_data;
    exe.imm      <= imm;
    exe.a_is_pc  <= a_is_pc;
    exe.b_is_imm <= b_is_imm;
    if (rst) begin
      exe.valid    <= 1'b0;
      exe.rd_we    <= 1'b0;
      exe.is_ecall <= 1'b0;
    end else begin
      exe.valid    <= dec.valid;
      exe.rd_we    <= dec.valid && writes && (rd != 5'd0);
      exe.is_ecall <= dec.valid && is_ecall;
    end
  end

endmodule

// File: source/reg_file.sv
module reg_file (
  input  logic                clk,
  input  logic                rst,
  input  riscv_pkg::reg_idx_t rs1,
  input  riscv_pkg::reg_idx_t rs2,
  input  riscv_pkg::wb_t      wr,
  output riscv_pkg::word_t    rs1_data,
  output riscv_pkg::word_t    rs2_data
);
  import riscv_pkg::*;

  // x0 has no storage
  word_t regs [1:31];
  logic  we;

  assign we = wr.valid && wr.rd_we && (wr.rd != 5'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr.rd] <= wr.rd_data;
    end
  end

  // same-cycle write is visible on the read ports
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1 != 5'd0) begin
      rs1_data = (we && wr.rd == rs1) ? wr.rd_data : regs[rs1];
    end
    if (rs2 != 5'd0) begin
      rs2_data = (we && wr.rd == rs2) ? wr.rd_data : regs[rs2];
    end
  end

endmodule

// File: source/execute_unit.sv
module execute_unit (
  input  logic             clk,
  input  logic             rst,
  input  riscv_pkg::exec_t exe,
  output riscv_pkg::wb_t   wb,
  output logic             halt
);
  import riscv_pkg::*;

  word_t      rs1_val;
  word_t      rs2_val;
  word_t      op_a;
  word_t      op_b;
  word_t      result;
  logic [4:0] shamt;
  logic       fwd_ok;
  logic       halted;

  // forward from writeback since rd_we is never set for x0
  assign fwd_ok  = wb.valid && wb.rd_we;
  assign rs1_val = (fwd_ok && wb.rd == exe.rs1) ? wb.rd_data : exe.rs1_data;
  assign rs2_val = (fwd_ok && wb.rd == exe.rs2) ? wb.rd_data : exe.rs2_data;

  assign op_a  = exe.a_is_pc ? exe.pc : rs1_val;
  assign op_b  = exe.b_is_imm ? exe.imm : rs2_val;
  assign shamt = op_b[4:0];

  always_comb begin
    case (exe.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {31'd0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {31'd0, op_a < op_b};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = word_t'($signed(op_a) >>> shamt);
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    wb.pc      <= exe.pc;
    wb.insn    <= exe.insn;
    wb.rd      <= exe.rd;
    wb.rd_data <= result;
    if (rst) begin
      wb.valid    <= 1'b0;
      wb.rd_we    <= 1'b0;
      wb.is_ecall <= 1'b0;
    end else begin
      wb.valid    <= exe.valid;
      wb.rd_we    <= exe.valid && exe.rd_we;
      wb.is_ecall <= exe.valid && exe.is_ecall;
    end
  end

  // sticky once the ecall has retired
  always_ff @(posedge clk) begin
    if (rst) begin
      halted <= 1'b0;
    end else if (wb.valid && wb.is_ecall) begin
      halted <= 1'b1;
    end
  end

  assign halt = halted || (wb.valid && wb.is_ecall);

endmodule

// File: source/rv_core.sv
module rv_core #(
  parameter int IMEM_WORDS = 64
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load_en,
  input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
  input  riscv_pkg::word_t              load_insn,
  input  logic                          run,
  output logic                          halt,
  output riscv_pkg::wb_t                retire
);
  import riscv_pkg::*;

  word_t    fetch_pc;
  word_t    fetch_insn;
  decode_t  dec;
  exec_t    exe;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     stop_fetch;

  instr_mem #(
    .IMEM_WORDS(IMEM_WORDS)
  ) instr_mem_inst (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_insn (load_insn),
    .fetch_pc  (fetch_pc),
    .fetch_insn(fetch_insn)
  );

  fetch_unit fetch_unit_inst (
    .clk       (clk),
    .rst       (rst),
    .run       (run),
    .stop_fetch(stop_fetch),
    .fetch_insn(fetch_insn),
    .fetch_pc  (fetch_pc),
    .dec       (dec)
  );

  decode_unit decode_unit_inst (
    .clk       (clk),
    .rst       (rst),
    .dec       (dec),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .rs1       (rs1),
    .rs2       (rs2),
    .stop_fetch(stop_fetch),
    .exe       (exe)
  );

  // written from the writeback stage that also drives the retire trace
  reg_file reg_file_inst (
    .clk     (clk),
    .rst     (rst),
    .rs1     (rs1),
    .rs2     (rs2),
    .wr      (retire),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  execute_unit execute_unit_inst (
    .clk (clk),
    .rst (rst),
    .exe (exe),
    .wb  (retire),
    .halt(halt)
  );

endmodule

// File: sim/rv_core_sva.sv
module rv_core_sva (
  input logic           clk,
  input logic           rst,
  input logic           halt,
  input riscv_pkg::wb_t retire
);
  timeunit 1ns;
  timeprecision 100ps;

  // halt only clears through reset
  halt_sticky_a: assert property (@(posedge clk) $fell(halt) |-> $past(rst))
    else $error("halt fell while rst was low");

  // x0 is never a write target
  rd_nonzero_a: assert property (@(posedge clk) disable iff (rst)
    retire.rd_we |-> retire.rd != 5'd0)
    else $error("retire has rd_we set with rd of zero");

  // one edge of reset clears the writeback stage
  no_retire_in_reset_a: assert property (@(posedge clk)
    rst && $past(rst) |-> !retire.valid)
    else $error("retire valid while rst is high");

endmodule

bind rv_core rv_core_sva rv_core_sva_inst (
  .clk   (clk),
  .rst   (rst),
  .halt  (halt),
  .retire(retire)
);

// File: sim/tb_rv_core.sv
module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;
  import riscv_pkg::*;

  localparam int IMEM_WORDS = 64;
  localparam int AW = $clog2(IMEM_WORDS);
  localparam word_t ECALL_INSN = 32'h0000_0073;

  // one expected retirement from the trace
  typedef struct packed {
    word_t    pc;
    word_t    insn;
    logic     rd_we;
    reg_idx_t rd;
    word_t    rd_data;
  } expect_t;

  typedef struct packed {
    logic [AW-1:0] addr;
    word_t         insn;
  } load_t;

  logic          clk;
  logic          rst;
  logic          load_en;
  logic [AW-1:0] load_addr;
  word_t         load_insn;
  logic          run;
  logic          halt;
  wb_t           retire;

  load_t   loads[$];
  expect_t expected[$];
  int      retired = 0;
  int      value_errors = 0;
  int      other_errors = 0;
  logic    run_started = 1'b0;
  logic    ecall_retired = 1'b0;
  logic    trace_ready = 1'b0;

  rv_core #(
    .IMEM_WORDS(IMEM_WORDS)
  ) rv_core_inst (
    .clk      (clk),
    .rst      (rst),
    .load_en  (load_en),
    .load_addr(load_addr),
    .load_insn(load_insn),
    .run      (run),
    .halt     (halt),
    .retire   (retire)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic read_trace();
    int          fd;
    int          n;
    string       line;
    string       rest;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    logic [31:0] f5;
    load_t       ld;
    expect_t     ex;
    fd = $fopen("sim/program_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file sim/program_trace.txt");
      other_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 1 && (line[0] == "L" || line[0] == "E")) begin
        rest = line.substr(1, line.len() - 1);
        if (line[0] == "L") begin
          n = $sscanf(rest, "%h %h", f1, f2);
          ld.addr = f1[AW-1:0];
          ld.insn = f2;
          if (n == 2) begin
            loads.push_back(ld);
          end else begin
            $display("malformed trace line: %s", line);
            other_errors++;
          end
        end else begin
          n = $sscanf(rest, "%h %h %h %h %h", f1, f2, f3, f4, f5);
          ex.pc      = f1;
          ex.insn    = f2;
          ex.rd_we   = f3[0];
          ex.rd      = f4[4:0];
          ex.rd_data = f5;
          if (n == 5) begin
            expected.push_back(ex);
          end else begin
            $display("malformed trace line: %s", line);
            other_errors++;
          end
        end
      end
    end
    $fclose(fd);
    if (expected.size() == 0) begin
      $display("the trace holds no expected retirements");
      other_errors++;
    end
  endtask

  task automatic value_mismatch(input string what, input word_t got, input word_t exp);
    $display("Fail at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    value_errors++;
  endtask

  task automatic check_retire();
    expect_t e;
    if (!run_started) begin
      $display("a retirement showed up at %0d ns before run was ever raised", $time);
      other_errors++;
    end else if (retired >= expected.size()) begin
      $display("extra retirement at %0d ns, pc %h, after the last expected one",
               $time, retire.pc);
      other_errors++;
    end else begin
      e = expected[retired];
      if (retire.pc != e.pc) value_mismatch("pc", retire.pc, e.pc);
      if (retire.insn != e.insn) value_mismatch("insn", retire.insn, e.insn);
      if (retire.rd_we != e.rd_we) begin
        value_mismatch("rd_we", word_t'(retire.rd_we), word_t'(e.rd_we));
      end
      if (retire.rd != e.rd) value_mismatch("rd", word_t'(retire.rd), word_t'(e.rd));
      // result only matters when a register is written
      if (e.rd_we && retire.rd_data != e.rd_data) begin
        value_mismatch("rd_data", retire.rd_data, e.rd_data);
      end
      if (retire.is_ecall != (e.insn == ECALL_INSN)) begin
        value_mismatch("is_ecall", word_t'(retire.is_ecall), word_t'(e.insn == ECALL_INSN));
      end
      if (e.insn == ECALL_INSN) ecall_retired = 1'b1;
      retired++;
    end
  endtask

  // outputs settle after the rising edge so sample in the middle
  always @(negedge clk) begin
    if (!rst) begin
      if (retire.valid) check_retire();
      if (halt != ecall_retired) begin
        value_mismatch("halt", word_t'(halt), word_t'(ecall_retired));
      end
    end
  end

  initial begin
    int limit;
    wait (trace_ready);
    limit = loads.size() + 4 * expected.size() + 50;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, only %0d of %0d retirements seen",
             limit, retired, expected.size());
    $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int gap;
    rst       = 1'b1;
    load_en   = 1'b0;
    load_addr = '0;
    load_insn = '0;
    run       = 1'b0;
    void'($urandom(90));
    read_trace();
    trace_ready = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // program goes in while the core is idle
    foreach (loads[i]) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= loads[i].addr;
      load_insn <= loads[i].insn;
    end
    @(posedge clk);
    load_en <= 1'b0;
    repeat (3) @(posedge clk);
    while (retired < expected.size()) begin
      @(posedge clk);
      run         <= 1'b1;
      run_started <= 1'b1;
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge clk);
        run <= 1'b0;
      end
    end
    // fetch must stay stopped after the ecall
    @(posedge clk);
    run <= 1'b1;
    repeat (8) @(posedge clk);
    run <= 1'b0;
    @(posedge clk);
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: sim/program_trace.txt
# L word_addr insn                      program word, hex
# E pc insn rd_we rd rd_data            expected retirement in order, hex
L 00 800000b7
L 01 fff08113
L 02 0000a193
L 03 fff13213
L 04 55514293
L 05 ff01e313
L 06 0f02f393
L 07 00439413
L 08 01f0d493
L 09 4040d513
L 0a 12345597
L 0b 00310633
L 0c 402606b3
L 0d 00669733
L 0e 0020a7b3
L 0f 0020b833
L 10 0062c8b3
L 11 00955933
L 12 409559b3
L 13 01396a33
L 14 00ba7033
L 15 00ba7ab3
L 16 00e00b33
L 17 00000073
L 18 00100093
E 00000000 800000b7 1 01 80000000
E 00000004 fff08113 1 02 7fffffff
E 00000008 0000a193 1 03 00000001
E 0000000c fff13213 1 04 00000001
E 00000010 55514293 1 05 7ffffaaa
E 00000014 ff01e313 1 06 fffffff1
E 00000018 0f02f393 1 07 000000a0
E 0000001c 00439413 1 08 00000a00
E 00000020 01f0d493 1 09 00000001
E 00000024 4040d513 1 0a f8000000
E 00000028 12345597 1 0b 12345028
E 0000002c 00310633 1 0c 80000000
E 00000030 402606b3 1 0d 00000001
E 00000034 00669733 1 0e 00020000
E 00000038 0020a7b3 1 0f 00000001
E 0000003c 0020b833 1 10 00000000
E 00000040 0062c8b3 1 11 8000055b
E 00000044 00955933 1 12 7c000000
E 00000048 409559b3 1 13 fc000000
E 0000004c 01396a33 1 14 fc000000
E 00000050 00ba7033 0 00 00000000
E 00000054 00ba7ab3 1 15 10000000
E 00000058 00e00b33 1 16 00020000
E 0000005c 00000073 0 00 00000000

// File: all.f
source/riscv_pkg.sv
source/instr_mem.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/rv_core.sv
sim/rv_core_sva.sv
sim/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# compile and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_rv_core -f all.f -o vsim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/vsim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0
